// ==== common/dcachePkg.sv ====
package dcachePkg;

    localparam int ADDR_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int SETS           = 4;
    localparam int WAYS           = 2;
    localparam int LINES          = SETS * WAYS;

    typedef logic [ADDR_W-1:0] addrT;
    typedef logic [31:0]       wordT;
    typedef logic [3:0]        maskT;
    typedef logic [1:0]        setIdxT;
    typedef logic [0:0]        wayIdxT;
    // Address bits 31:6
    typedef logic [25:0]       tagT;
    typedef logic [1:0]        wordIdxT;
    // Way, set and word
    typedef logic [4:0]        sramAddrT;

    typedef enum logic [2:0] {
        IDLE,
        EVICT_RQ,
        EVICT_ACTIVE,
        LOAD_RQ,
        LOAD_ACTIVE
    } ctrlStateT;

    typedef enum logic [1:0] {
        COPY_NONE,
        COPY_EXT_TO_CACHE,
        COPY_CACHE_TO_EXT
    } copyCmdT;

    // Value 2 behaves as a clean
    typedef enum logic [1:0] {
        MGMT_CLEAN = 2'd0,
        MGMT_INVAL = 2'd1,
        MGMT_FLUSH = 2'd3
    } mgmtOpT;

endpackage

// ==== cacheController/tagLookup.sv ====
module tagLookup
    import dcachePkg::*;
(
    input  addrT            addr,
    input  logic [WAYS-1:0] wayValid,
    input  logic [WAYS-1:0] wayUsed,
    input  tagT             wayTag [WAYS],
    output logic            hit,
    output wayIdxT          hitWay,
    output logic            freeAvail,
    output wayIdxT          freeWay,
    output wayIdxT          victimWay
);

    tagT addrTag;

    assign addrTag = addr[ADDR_W-1:6];

    always_comb begin
        hit       = 1'b0;
        hitWay    = '0;
        freeAvail = 1'b0;
        freeWay   = '0;
        victimWay = '0;
        // Walk down so the lowest matching way wins
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (wayValid[w] && wayTag[w] == addrTag) begin
                hit    = 1'b1;
                hitWay = wayIdxT'(w);
            end
            if (!wayValid[w]) begin
                freeAvail = 1'b1;
                freeWay   = wayIdxT'(w);
            end
            if (!wayUsed[w]) begin
                victimWay = wayIdxT'(w);
            end
        end
    end

endmodule

// ==== cacheController/cacheController.sv ====
module cacheController
    import dcachePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ldValid,
    input  addrT     ldAddr,
    output logic     ldStall,
    output logic     ldDataValid,
    input  logic     stValid,
    input  addrT     stAddr,
    input  wordT     stData,
    input  maskT     stMask,
    output logic     stStall,
    input  logic     fence,
    output logic     fenceBusy,
    output logic     copyValid,
    output copyCmdT  copyCmd,
    output logic [$bits(wayIdxT)+$bits(setIdxT)-1:0] copySlot,
    output addrT     copyLineAddr,
    input  logic     copyBusy,
    input  logic     copyDone,
    output logic     portRdEn,
    output sramAddrT portRdAddr,
    output logic     portWrEn,
    output sramAddrT portWrAddr,
    output wordT     portWrData,
    output maskT     portWrMask
);

    ctrlStateT state;

    logic [WAYS-1:0] validArr [SETS];
    logic [WAYS-1:0] dirtyArr [SETS];
    logic [WAYS-1:0] usedArr [SETS];
    tagT             tagArr [SETS][WAYS];

    setIdxT ldSet;
    setIdxT stSet;
    logic   ldHit;
    wayIdxT ldHitWay;
    logic   ldFreeAvail;
    wayIdxT ldFreeWay;
    wayIdxT ldVictimWay;
    logic   stHit;
    wayIdxT stHitWay;
    logic   stFreeAvail;
    wayIdxT stFreeWay;
    wayIdxT stVictimWay;

    sramAddrT ldSramAddr;
    logic     portFree;
    logic     rawHazard;
    logic     ldAccept;
    logic     isMgmt;
    logic     stWrAccept;
    logic     mgmtAccept;
    mgmtOpT   mgmtOp;

    logic   ldMiss;
    logic   stMiss;
    logic   missReq;
    addrT   missAddr;
    setIdxT missSet;
    logic   missFreeAvail;
    wayIdxT missFreeWay;
    wayIdxT missVictim;
    logic   victimDirty;

    logic                  flushWaiting;
    logic                  flushActive;
    logic [$clog2(LINES):0] flushIter;
    logic                  flushEnd;
    setIdxT                flushSet;
    wayIdxT                flushWay;
    logic                  flushStep;

    copyCmdT orderCmd;
    wayIdxT  orderWay;
    setIdxT  orderSet;
    addrT    orderAddr;
    logic    dropLine;
    logic    cleanLine;
    wayIdxT  slotWay;
    setIdxT  slotSet;

    assign ldSet = ldAddr[5:4];
    assign stSet = stAddr[5:4];
    assign {flushEnd, flushSet, flushWay} = flushIter;
    assign {slotWay, slotSet} = copySlot;

    tagLookup ldLookup (
        .addr      (ldAddr),
        .wayValid  (validArr[ldSet]),
        .wayUsed   (usedArr[ldSet]),
        .wayTag    (tagArr[ldSet]),
        .hit       (ldHit),
        .hitWay    (ldHitWay),
        .freeAvail (ldFreeAvail),
        .freeWay   (ldFreeWay),
        .victimWay (ldVictimWay)
    );

    tagLookup stLookup (
        .addr      (stAddr),
        .wayValid  (validArr[stSet]),
        .wayUsed   (usedArr[stSet]),
        .wayTag    (tagArr[stSet]),
        .hit       (stHit),
        .hitWay    (stHitWay),
        .freeAvail (stFreeAvail),
        .freeWay   (stFreeWay),
        .victimWay (stVictimWay)
    );

    assign ldSramAddr = {ldHitWay, ldSet, ldAddr[3:2]};
    assign portFree   = state == IDLE && !flushActive;
    // Store data lands one cycle late, so a load of that word waits
    assign rawHazard  = portWrEn && portWrAddr == ldSramAddr;
    assign ldAccept   = ldValid && ldHit && portFree && !rawHazard;
    assign isMgmt     = stMask == '0;
    assign mgmtOp     = mgmtOpT'(stData[1:0]);
    assign stWrAccept = stValid && !isMgmt && stHit && portFree;
    assign mgmtAccept = stValid && isMgmt && portFree && !ldValid;
    assign ldStall    = ldValid && !ldAccept;
    assign stStall    = stValid && !(stWrAccept || mgmtAccept);
    assign portRdEn   = ldAccept;
    assign portRdAddr = ldSramAddr;
    assign fenceBusy  = fence || flushWaiting || flushActive;

    // Load port has priority for the state machine
    assign ldMiss        = ldValid && !ldHit;
    assign stMiss        = stValid && !isMgmt && !stHit;
    assign missReq       = portFree && (ldMiss || stMiss);
    assign missAddr      = ldMiss ? ldAddr : stAddr;
    assign missSet       = ldMiss ? ldSet : stSet;
    assign missFreeAvail = ldMiss ? ldFreeAvail : stFreeAvail;
    assign missFreeWay   = ldMiss ? ldFreeWay : stFreeWay;
    assign missVictim    = ldMiss ? ldVictimWay : stVictimWay;
    assign victimDirty   = dirtyArr[missSet][missVictim] ||
        (ldMiss && stWrAccept && stSet == ldSet && stHitWay == ldVictimWay);

    always_comb begin
        orderCmd  = COPY_NONE;
        orderWay  = flushWay;
        orderSet  = flushSet;
        orderAddr = {tagArr[flushSet][flushWay], flushSet, 4'b0000};
        dropLine  = 1'b0;
        cleanLine = 1'b0;
        flushStep = 1'b0;
        if (flushActive) begin
            if (!flushEnd) begin
                if (!validArr[flushSet][flushWay] || !dirtyArr[flushSet][flushWay]) begin
                    dropLine  = 1'b1;
                    flushStep = 1'b1;
                end else if (state == IDLE) begin
                    orderCmd  = COPY_CACHE_TO_EXT;
                    dropLine  = 1'b1;
                    flushStep = 1'b1;
                end
            end
        end else if (mgmtAccept) begin
            orderWay  = stHitWay;
            orderSet  = stSet;
            orderAddr = {tagArr[stSet][stHitWay], stSet, 4'b0000};
            if (stHit && mgmtOp != MGMT_INVAL && dirtyArr[stSet][stHitWay]) begin
                orderCmd  = COPY_CACHE_TO_EXT;
                cleanLine = 1'b1;
            end
            if (stHit && (mgmtOp == MGMT_INVAL || mgmtOp == MGMT_FLUSH)) begin
                dropLine = 1'b1;
            end
        end else if (missReq) begin
            orderSet = missSet;
            if (missFreeAvail) begin
                orderCmd  = COPY_EXT_TO_CACHE;
                orderWay  = missFreeWay;
                orderAddr = {missAddr[ADDR_W-1:4], 4'b0000};
            end else begin
                // Clean victims are dropped without a bus transfer
                orderWay  = missVictim;
                orderAddr = {tagArr[missSet][missVictim], missSet, 4'b0000};
                dropLine  = 1'b1;
                if (victimDirty) begin
                    orderCmd = COPY_CACHE_TO_EXT;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            copyValid    <= 1'b0;
            copyCmd      <= COPY_NONE;
            ldDataValid  <= 1'b0;
            portWrEn     <= 1'b0;
            flushWaiting <= 1'b0;
            flushActive  <= 1'b0;
            flushIter    <= '0;
            for (int s = 0; s < SETS; s++) begin
                validArr[s] <= '0;
                dirtyArr[s] <= '0;
                usedArr[s]  <= '0;
            end
        end else begin
            ldDataValid <= ldAccept;
            portWrEn    <= stWrAccept;

            case (state)
                EVICT_RQ: begin
                    if (copyBusy) begin
                        copyValid <= 1'b0;
                        state     <= EVICT_ACTIVE;
                    end
                end
                LOAD_RQ: begin
                    if (copyBusy) begin
                        copyValid <= 1'b0;
                        state     <= LOAD_ACTIVE;
                    end
                end
                EVICT_ACTIVE: begin
                    if (copyDone) begin
                        state <= IDLE;
                    end
                end
                LOAD_ACTIVE: begin
                    if (copyDone) begin
                        state                     <= IDLE;
                        validArr[slotSet][slotWay] <= 1'b1;
                    end
                end
                default: begin
                    if (orderCmd == COPY_EXT_TO_CACHE) begin
                        copyValid <= 1'b1;
                        copyCmd   <= orderCmd;
                        state     <= LOAD_RQ;
                    end else if (orderCmd == COPY_CACHE_TO_EXT) begin
                        copyValid <= 1'b1;
                        copyCmd   <= orderCmd;
                        state     <= EVICT_RQ;
                    end
                end
            endcase

            if (ldAccept) begin
                usedArr[ldSet]           <= '0;
                usedArr[ldSet][ldHitWay] <= 1'b1;
            end
            if (stWrAccept) begin
                usedArr[stSet]            <= '0;
                usedArr[stSet][stHitWay]  <= 1'b1;
                dirtyArr[stSet][stHitWay] <= 1'b1;
            end
            // Drops come last so an evicted line ends up clear
            if (cleanLine) begin
                dirtyArr[orderSet][orderWay] <= 1'b0;
            end
            if (dropLine) begin
                validArr[orderSet][orderWay] <= 1'b0;
                dirtyArr[orderSet][orderWay] <= 1'b0;
                usedArr[orderSet][orderWay]  <= 1'b0;
            end

            if (fence) begin
                flushWaiting <= 1'b1;
            end else if (flushWaiting && !ldValid && !stValid && state == IDLE) begin
                flushWaiting <= 1'b0;
                flushActive  <= 1'b1;
                flushIter    <= '0;
            end
            if (flushActive) begin
                if (flushStep) begin
                    flushIter <= flushIter + 1'b1;
                end else if (flushEnd && state == IDLE) begin
                    flushActive <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (orderCmd != COPY_NONE) begin
            copySlot     <= {orderWay, orderSet};
            copyLineAddr <= orderAddr;
        end
        if (state == LOAD_ACTIVE && copyDone) begin
            tagArr[slotSet][slotWay] <= copyLineAddr[ADDR_W-1:6];
        end
        if (stWrAccept) begin
            portWrAddr <= {stHitWay, stSet, stAddr[3:2]};
            portWrData <= stData;
            portWrMask <= stMask;
        end
    end

endmodule

// ==== src/lineCopier.sv ====
module lineCopier
    import dcachePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     copyValid,
    input  copyCmdT  copyCmd,
    input  logic [$bits(wayIdxT)+$bits(setIdxT)-1:0] copySlot,
    input  addrT     copyLineAddr,
    output logic     copyBusy,
    output logic     copyDone,
    output logic     cpRdEn,
    output sramAddrT cpRdAddr,
    input  wordT     cpRdData,
    output logic     cpWrEn,
    output sramAddrT cpWrAddr,
    output wordT     cpWrData,
    output logic     wbCyc,
    output logic     wbStb,
    output logic     wbWe,
    output addrT     wbAdr,
    output maskT     wbSel,
    output wordT     wbDatW,
    input  wordT     wbDatR,
    input  logic     wbAck
);

    typedef enum logic [2:0] {
        CP_IDLE,
        CP_READ,
        CP_NEXT,
        CP_BUS,
        CP_DONE
    } copyStateT;

    copyStateT state;
    logic [$bits(wayIdxT)+$bits(setIdxT)-1:0] slot;
    addrT    lineAddr;
    wordIdxT wordCnt;
    wordIdxT rdWord;
    logic    lastWord;

    assign lastWord = wordCnt == wordIdxT'(WORDS_PER_LINE - 1);
    // Writeback fetches the next word already in the ack cycle
    assign rdWord   = (state == CP_BUS) ? wordCnt + 1'b1 : wordCnt;
    assign cpRdEn   = state == CP_READ || (state == CP_BUS && wbAck && wbWe && !lastWord);
    assign cpRdAddr = {slot, rdWord};
    assign wbAdr    = {lineAddr[ADDR_W-1:4], wordCnt, 2'b00};
    assign wbSel    = '1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= CP_IDLE;
            copyBusy <= 1'b0;
            copyDone <= 1'b0;
            cpWrEn   <= 1'b0;
            wbCyc    <= 1'b0;
            wbStb    <= 1'b0;
        end else begin
            copyDone <= 1'b0;
            cpWrEn   <= 1'b0;
            case (state)
                CP_IDLE: begin
                    if (copyValid && copyCmd != COPY_NONE) begin
                        copyBusy <= 1'b1;
                        if (copyCmd == COPY_EXT_TO_CACHE) begin
                            wbCyc <= 1'b1;
                            wbStb <= 1'b1;
                            state <= CP_BUS;
                        end else begin
                            state <= CP_READ;
                        end
                    end
                end
                CP_READ: state <= CP_NEXT;
                CP_NEXT: begin
                    wbCyc <= 1'b1;
                    wbStb <= 1'b1;
                    state <= CP_BUS;
                end
                CP_BUS: begin
                    if (wbAck) begin
                        wbCyc  <= 1'b0;
                        wbStb  <= 1'b0;
                        cpWrEn <= !wbWe;
                        if (lastWord) begin
                            copyDone <= 1'b1;
                            state    <= CP_DONE;
                        end else begin
                            state <= CP_NEXT;
                        end
                    end
                end
                // Last fill word is written here, still under copyBusy
                CP_DONE: begin
                    copyBusy <= 1'b0;
                    state    <= CP_IDLE;
                end
                default: state <= CP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == CP_IDLE && copyValid) begin
            slot     <= copySlot;
            lineAddr <= copyLineAddr;
            wbWe     <= copyCmd == COPY_CACHE_TO_EXT;
            wordCnt  <= '0;
        end
        if (state == CP_BUS && wbAck) begin
            wordCnt  <= wordCnt + 1'b1;
            cpWrAddr <= {slot, wordCnt};
            cpWrData <= wbDatR;
        end
        if (state == CP_NEXT && wbWe) begin
            wbDatW <= cpRdData;
        end
    end

endmodule

// ==== src/dataArbiter.sv ====
module dataArbiter
    import dcachePkg::*;
(
    input  logic     clk,
    input  logic     copyBusy,
    input  logic     cpRdEn,
    input  sramAddrT cpRdAddr,
    input  logic     cpWrEn,
    input  sramAddrT cpWrAddr,
    input  wordT     cpWrData,
    output wordT     cpRdData,
    input  logic     portRdEn,
    input  sramAddrT portRdAddr,
    input  logic     portWrEn,
    input  sramAddrT portWrAddr,
    input  wordT     portWrData,
    input  maskT     portWrMask,
    output wordT     portRdData
);

    wordT     mem [LINES * WORDS_PER_LINE];
    wordT     rdData;
    logic     rdEn;
    sramAddrT rdAddr;
    logic     wrEn;
    sramAddrT wrAddr;
    wordT     wrData;
    maskT     wrMask;

    // Copier owns the memory for the whole transfer
    always_comb begin
        if (copyBusy) begin
            rdEn   = cpRdEn;
            rdAddr = cpRdAddr;
            wrEn   = cpWrEn;
            wrAddr = cpWrAddr;
            wrData = cpWrData;
            wrMask = '1;
        end else begin
            rdEn   = portRdEn;
            rdAddr = portRdAddr;
            wrEn   = portWrEn;
            wrAddr = portWrAddr;
            wrData = portWrData;
            wrMask = portWrMask;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            for (int b = 0; b < $bits(maskT); b++) begin
                if (wrMask[b]) begin
                    mem[wrAddr][8*b +: 8] <= wrData[8*b +: 8];
                end
            end
        end
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

    assign cpRdData   = rdData;
    assign portRdData = rdData;

endmodule

// ==== src/dcacheTop.sv ====
module dcacheTop
    import dcachePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic ldValid,
    input  addrT ldAddr,
    output logic ldStall,
    output logic ldDataValid,
    output wordT ldData,
    input  logic stValid,
    input  addrT stAddr,
    input  wordT stData,
    input  maskT stMask,
    output logic stStall,
    input  logic fence,
    output logic fenceBusy,
    output logic wbCyc,
    output logic wbStb,
    output logic wbWe,
    output addrT wbAdr,
    output maskT wbSel,
    output wordT wbDatW,
    input  wordT wbDatR,
    input  logic wbAck
);

    logic     copyValid;
    copyCmdT  copyCmd;
    logic [$bits(wayIdxT)+$bits(setIdxT)-1:0] copySlot;
    addrT     copyLineAddr;
    logic     copyBusy;
    logic     copyDone;
    logic     cpRdEn;
    sramAddrT cpRdAddr;
    wordT     cpRdData;
    logic     cpWrEn;
    sramAddrT cpWrAddr;
    wordT     cpWrData;
    logic     portRdEn;
    sramAddrT portRdAddr;
    logic     portWrEn;
    sramAddrT portWrAddr;
    wordT     portWrData;
    maskT     portWrMask;

    cacheController u_cacheController (
        .clk          (clk),
        .rst          (rst),
        .ldValid      (ldValid),
        .ldAddr       (ldAddr),
        .ldStall      (ldStall),
        .ldDataValid  (ldDataValid),
        .stValid      (stValid),
        .stAddr       (stAddr),
        .stData       (stData),
        .stMask       (stMask),
        .stStall      (stStall),
        .fence        (fence),
        .fenceBusy    (fenceBusy),
        .copyValid    (copyValid),
        .copyCmd      (copyCmd),
        .copySlot     (copySlot),
        .copyLineAddr (copyLineAddr),
        .copyBusy     (copyBusy),
        .copyDone     (copyDone),
        .portRdEn     (portRdEn),
        .portRdAddr   (portRdAddr),
        .portWrEn     (portWrEn),
        .portWrAddr   (portWrAddr),
        .portWrData   (portWrData),
        .portWrMask   (portWrMask)
    );

    lineCopier u_lineCopier (
        .clk          (clk),
        .rst          (rst),
        .copyValid    (copyValid),
        .copyCmd      (copyCmd),
        .copySlot     (copySlot),
        .copyLineAddr (copyLineAddr),
        .copyBusy     (copyBusy),
        .copyDone     (copyDone),
        .cpRdEn       (cpRdEn),
        .cpRdAddr     (cpRdAddr),
        .cpRdData     (cpRdData),
        .cpWrEn       (cpWrEn),
        .cpWrAddr     (cpWrAddr),
        .cpWrData     (cpWrData),
        .wbCyc        (wbCyc),
        .wbStb        (wbStb),
        .wbWe         (wbWe),
        .wbAdr        (wbAdr),
        .wbSel        (wbSel),
        .wbDatW       (wbDatW),
        .wbDatR       (wbDatR),
        .wbAck        (wbAck)
    );

    dataArbiter u_dataArbiter (
        .clk        (clk),
        .copyBusy   (copyBusy),
        .cpRdEn     (cpRdEn),
        .cpRdAddr   (cpRdAddr),
        .cpWrEn     (cpWrEn),
        .cpWrAddr   (cpWrAddr),
        .cpWrData   (cpWrData),
        .cpRdData   (cpRdData),
        .portRdEn   (portRdEn),
        .portRdAddr (portRdAddr),
        .portWrEn   (portWrEn),
        .portWrAddr (portWrAddr),
        .portWrData (portWrData),
        .portWrMask (portWrMask),
        .portRdData (ldData)
    );

endmodule

// ==== verification/extMemModel.sv ====
module extMemModel
    import dcachePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic wbCyc,
    input  logic wbStb,
    input  logic wbWe,
    input  addrT wbAdr,
    input  maskT wbSel,
    input  wordT wbDatW,
    output wordT wbDatR,
    output logic wbAck
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 KB of backing store
    localparam int MEM_WORDS = 1024;

    wordT mem [MEM_WORDS];
    int   seed;
    logic pending;
    int   waitLeft;
    int   delay;

    initial begin
        seed     = 32'h4445_6bc7;
        wbAck    = 1'b0;
        wbDatR   = '0;
        pending  = 1'b0;
        waitLeft = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = addrT'(4 * i) ^ 32'hA5A5_0000;
        end
    end

    // Each word waits 0 to 3 extra cycles before the ack
    always @(posedge clk) begin
        wbAck <= 1'b0;
        if (rst) begin
            pending <= 1'b0;
        end else if (wbCyc && wbStb && !wbAck) begin
            delay = pending ? waitLeft : ($random(seed) & 3);
            if (delay == 0) begin
                wbAck   <= 1'b1;
                pending <= 1'b0;
                wbDatR  <= mem[wbAdr[11:2]];
                if (wbWe) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wbSel[b]) begin
                            mem[wbAdr[11:2]][8*b +: 8] <= wbDatW[8*b +: 8];
                        end
                    end
                end
            end else begin
                pending  <= 1'b1;
                waitLeft <= delay - 1;
            end
        end
    end

endmodule

// ==== verification/dcacheTb.sv ====
module dcacheTb
    import dcachePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int MEM_WORDS  = 1024;
    localparam int WAIT_LIMIT = 200;
    // About 25 cache operations, none longer than 100 cycles
    localparam int TEST_OPS      = 25;
    localparam int CYCLES_PER_OP = 100;
    localparam int WATCHDOG_NS   = TEST_OPS * CYCLES_PER_OP * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    logic ldValid;
    addrT ldAddr;
    logic ldStall;
    logic ldDataValid;
    wordT ldData;
    logic stValid;
    addrT stAddr;
    wordT stData;
    maskT stMask;
    logic stStall;
    logic fence;
    logic fenceBusy;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    addrT wbAdr;
    maskT wbSel;
    wordT wbDatW;
    wordT wbDatR;
    logic wbAck;

    int   seed;
    wordT refMem [MEM_WORDS];
    addrT wrAddrs [$];
    int   busReads = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcacheTop u_dcacheTop (
        .clk         (clk),
        .rst         (rst),
        .ldValid     (ldValid),
        .ldAddr      (ldAddr),
        .ldStall     (ldStall),
        .ldDataValid (ldDataValid),
        .ldData      (ldData),
        .stValid     (stValid),
        .stAddr      (stAddr),
        .stData      (stData),
        .stMask      (stMask),
        .stStall     (stStall),
        .fence       (fence),
        .fenceBusy   (fenceBusy),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAdr       (wbAdr),
        .wbSel       (wbSel),
        .wbDatW      (wbDatW),
        .wbDatR      (wbDatR),
        .wbAck       (wbAck)
    );

    extMemModel u_extMem (
        .clk    (clk),
        .rst    (rst),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbSel  (wbSel),
        .wbDatW (wbDatW),
        .wbDatR (wbDatR),
        .wbAck  (wbAck)
    );

    function automatic wordT initialWord(addrT a);
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic stopWithError(string msg);
        $display("FAIL at %0d ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic loadAndCheck(input addrT a, output int stalls);
        stalls = 0;
        @(posedge clk);
        ldValid <= 1'b1;
        ldAddr  <= a;
        @(negedge clk);
        while (ldStall) begin
            stalls++;
            if (stalls > WAIT_LIMIT) begin
                stopWithError($sformatf("load of %h was never accepted", a));
            end
            @(negedge clk);
        end
        @(posedge clk);
        ldValid <= 1'b0;
        @(negedge clk);
        assert (ldDataValid && ldData == refMem[a[11:2]])
            else stopWithError($sformatf("load of %h returned %h, expected %h",
                a, ldData, refMem[a[11:2]]));
    endtask

    task automatic loadExpectMiss(input addrT a);
        int readsBefore;
        int stalls;
        readsBefore = busReads;
        loadAndCheck(a, stalls);
        assert (busReads == readsBefore + WORDS_PER_LINE)
            else stopWithError($sformatf("load of %h did not refill its line", a));
    endtask

    task automatic storeWord(input addrT a, input wordT d, input maskT m);
        int waited;
        waited = 0;
        @(posedge clk);
        stValid <= 1'b1;
        stAddr  <= a;
        stData  <= d;
        stMask  <= m;
        @(negedge clk);
        while (stStall) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stopWithError($sformatf("store to %h was never accepted", a));
            end
            @(negedge clk);
        end
        // Taken at the coming edge
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                refMem[a[11:2]][8*b +: 8] = d[8*b +: 8];
            end
        end
        @(posedge clk);
        stValid <= 1'b0;
    endtask

    task automatic manageLine(input addrT a, input mgmtOpT op);
        storeWord(a, wordT'(op), 4'b0000);
    endtask

    task automatic runFence();
        int waited;
        waited = 0;
        @(posedge clk);
        fence <= 1'b1;
        @(posedge clk);
        fence <= 1'b0;
        @(negedge clk);
        assert (fenceBusy) else stopWithError("fenceBusy did not rise after the fence");
        while (fenceBusy) begin
            waited++;
            if (waited > 8 * WAIT_LIMIT) begin
                stopWithError("fence never finished its flush");
            end
            @(negedge clk);
        end
    endtask

    // Each group of four writes covers one line in ascending order
    task automatic checkBursts(input int lines);
        addrT expected;
        assert (wrAddrs.size() == 4 * lines)
            else stopWithError($sformatf("%0d words written back, expected %0d",
                wrAddrs.size(), 4 * lines));
        for (int i = 0; i < wrAddrs.size(); i++) begin
            expected = {wrAddrs[i - i % 4][31:4], 4'b0000} + 32'(4 * (i % 4));
            assert (wrAddrs[i] == expected)
                else stopWithError($sformatf("writeback word at %h, expected %h",
                    wrAddrs[i], expected));
        end
        wrAddrs.delete();
    endtask

    always @(posedge clk) begin
        if (!rst && wbCyc && wbStb && wbAck) begin
            if (wbWe) begin
                assert (wbDatW == refMem[wbAdr[11:2]])
                    else stopWithError($sformatf("writeback of %h carried %h, expected %h",
                        wbAdr, wbDatW, refMem[wbAdr[11:2]]));
                wrAddrs.push_back(wbAdr);
            end else begin
                busReads++;
            end
        end
    end

    stbNeedsCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
        else stopWithError("wbStb high without wbCyc");
    selAllOnes: assert property (@(posedge clk) disable iff (rst) wbCyc |-> wbSel == 4'hF)
        else stopWithError("wbSel not all ones during a cycle");
    holdUntilAck: assert property (@(posedge clk) disable iff (rst)
        wbStb && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbWe) &&
            (!wbWe || $stable(wbDatW)))
        else stopWithError("bus request changed before its ack");
    gapBetweenWords: assert property (@(posedge clk) disable iff (rst) wbStb && wbAck |=> !wbStb)
        else stopWithError("wbStb did not drop after an ack");
    addrInRange: assert property (@(posedge clk) disable iff (rst)
        wbCyc |-> wbAdr < 32'(4 * MEM_WORDS) && wbAdr[1:0] == 2'b00)
        else stopWithError("bus address outside the memory model or unaligned");
    quietInReset: assert property (@(posedge clk)
        rst |=> !ldDataValid && !ldStall && !stStall && !fenceBusy && !wbCyc && !wbStb)
        else stopWithError("outputs active during reset");
    loadLatency: assert property (@(posedge clk) disable iff (rst)
        ldValid && !ldStall |=> ldDataValid)
        else stopWithError("ldDataValid missing one cycle after an accepted load");
    noStrayData: assert property (@(posedge clk) disable iff (rst)
        !(ldValid && !ldStall) |=> !ldDataValid)
        else stopWithError("ldDataValid without an accepted load");

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests were still running after %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int stalls;
        int readsBefore;
        seed    = 32'h4445_6bc7;
        rst     = 1'b1;
        ldValid = 1'b0;
        ldAddr  = '0;
        stValid = 1'b0;
        stAddr  = '0;
        stData  = '0;
        stMask  = '0;
        fence   = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            refMem[i] = initialWord(addrT'(4 * i));
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        // Miss fills the line, then a hit with no stall
        loadExpectMiss(32'h100);
        loadAndCheck(32'h104, stalls);
        assert (stalls == 0) else stopWithError("load to a cached line stalled");

        storeWord(32'h104, $random(seed), 4'b0101);
        loadAndCheck(32'h104, stalls);
        storeWord(32'h108, $random(seed), 4'b1000);
        storeWord(32'h10C, $random(seed), 4'b1111);
        loadAndCheck(32'h108, stalls);
        loadAndCheck(32'h10C, stalls);

        // 0x140 and 0x180 share set 0 with the dirty line
        loadExpectMiss(32'h140);
        assert (wrAddrs.size() == 0) else stopWithError("fill into a free way wrote back");
        loadExpectMiss(32'h180);
        assert (wrAddrs.size() > 0 && wrAddrs[0] == 32'h100)
            else stopWithError("dirty line 0x100 was not written back");
        checkBursts(1);
        loadExpectMiss(32'h104);
        loadAndCheck(32'h10C, stalls);

        loadExpectMiss(32'h210);
        storeWord(32'h214, $random(seed), 4'b1111);
        manageLine(32'h210, MGMT_INVAL);
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            refMem[(32'h210 >> 2) + i] = initialWord(32'h210 + 4 * i);
        end
        loadExpectMiss(32'h214);
        assert (wrAddrs.size() == 0) else stopWithError("invalidated line was written back");

        loadExpectMiss(32'h220);
        storeWord(32'h228, $random(seed), 4'b1100);
        manageLine(32'h220, MGMT_CLEAN);
        readsBefore = busReads;
        loadAndCheck(32'h228, stalls);
        assert (busReads == readsBefore) else stopWithError("cleaned line was refetched");
        assert (wrAddrs.size() > 0 && wrAddrs[0] == 32'h220)
            else stopWithError("clean did not write back line 0x220");
        checkBursts(1);

        storeWord(32'h100, $random(seed), 4'b0011);
        storeWord(32'h184, $random(seed), 4'b1111);
        storeWord(32'h218, $random(seed), 4'b0110);
        storeWord(32'h22C, $random(seed), 4'b1111);
        runFence();
        checkBursts(4);
        for (int i = 0; i < MEM_WORDS; i++) begin
            assert (u_extMem.mem[i] == refMem[i])
                else stopWithError($sformatf("memory at %h holds %h, expected %h",
                    4 * i, u_extMem.mem[i], refMem[i]));
        end
        // Nothing survives the fence
        loadExpectMiss(32'h100);
        loadExpectMiss(32'h184);
        loadExpectMiss(32'h218);
        loadExpectMiss(32'h22C);
        assert (wrAddrs.size() == 0) else stopWithError("writeback after the fence");

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== dcacheTop.f ====
common/dcachePkg.sv
cacheController/tagLookup.sv
cacheController/cacheController.sv
src/lineCopier.sv
src/dataArbiter.sv
src/dcacheTop.sv
verification/extMemModel.sv
verification/dcacheTb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP        = dcacheTb
FILELIST   = dcacheTop.f
OBJ_DIR    = obj_dir
PASS_MSG   = PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
